// File: verilog/rename_pkg.sv
// sizes and the free-list phase shared by the rename side
// prf size must be larger than arf size
// both sizes are assumed to be powers of two, so every index value is a legal entry

package rename_pkg;

	//////////////////////////////
	// default sizes
	//////////////////////////////

	parameter int default_arf_size = 32;	// architectural registers
	parameter int default_prf_size = 64;	// physical registers, > arf

	//////////////////////////////
	// free list phase
	//////////////////////////////

	// run: normal alloc and release
	// recover: rebuild from the committed map, nothing handed out
	typedef enum logic {
		rec_run,
		rec_recover
	} recovery_state_e;

endpackage

// File: verilog/retire_pkg.sv
// retire event encoding, one per retire slot
// slots are in program order, slot 1 is the older

package retire_pkg;

	//////////////////////////////
	// retire slot kind
	//////////////////////////////

	// none: slot idle this cycle
	// commit: instruction retires normally
	// commit_mispredict: retires, then everything younger is squashed
	typedef enum logic [1:0] {
		retire_none              = 2'd0,
		retire_commit            = 2'd1,
		retire_commit_mispredict = 2'd2
	} retire_kind_e;

endpackage

// File: verilog/rename_map.sv
// speculative arch to phys map with two renames per cycle
// every renamed instruction is assumed to write a destination
// outputs are registered and payload only means something with out_valid
// no stall from downstream so a taken bundle always shows up next cycle
`timescale 1ns/1ps

module rename_map import rename_pkg::*; #(
	parameter int arf_size = default_arf_size,
	parameter int prf_size = default_prf_size,
	localparam int arch_w = $clog2(arf_size),
	localparam int phys_w = $clog2(prf_size)
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       in_valid1,
	input  logic                       in_valid2,
	input  logic [arch_w-1:0]          dest_arch1,
	input  logic [arch_w-1:0]          dest_arch2,
	input  logic [arch_w-1:0]          src1_arch1,
	input  logic [arch_w-1:0]          src2_arch1,
	input  logic [arch_w-1:0]          src1_arch2,
	input  logic [arch_w-1:0]          src2_arch2,
	input  logic [phys_w-1:0]          alloc_idx1,
	input  logic [phys_w-1:0]          alloc_idx2,
	input  logic                       ready,
	output logic                       alloc_take1,
	output logic                       alloc_take2,
	input  logic                       recover,
	input  logic [arf_size*phys_w-1:0] recovered_map,
	output logic                       out_valid1,
	output logic                       out_valid2,
	output logic [phys_w-1:0]          dest_phys1,
	output logic [phys_w-1:0]          dest_phys2,
	output logic [phys_w-1:0]          old_phys1,
	output logic [phys_w-1:0]          old_phys2,
	output logic [phys_w-1:0]          src1_phys1,
	output logic [phys_w-1:0]          src2_phys1,
	output logic [phys_w-1:0]          src1_phys2,
	output logic [phys_w-1:0]          src2_phys2
);

	logic [phys_w-1:0]   map_q [arf_size];	// speculative map
	logic                accept;
	logic [phys_w-1:0]   new_phys1, new_phys2;
	logic [phys_w-1:0]   old1_d, old2_d;
	logic [phys_w-1:0]   s11_d, s21_d, s12_d, s22_d;
	logic [prf_size-1:0] live;	// regs named by the speculative map

	//////////////////////////////
	// accept and allocation
	//////////////////////////////

	assign accept      = ready && !recover;	// all or nothing per bundle
	assign alloc_take1 = accept && in_valid1;
	assign alloc_take2 = accept && in_valid2;

	// a lone slot always gets the lowest free reg
	assign new_phys1 = alloc_idx1;
	assign new_phys2 = in_valid1 ? alloc_idx2 : alloc_idx1;

	//////////////////////////////
	// lookup with bundle bypass
	//////////////////////////////

	always_comb begin
		old1_d = map_q[dest_arch1];
		s11_d  = map_q[src1_arch1];
		s21_d  = map_q[src2_arch1];
		// slot 2 is younger and sees slot 1's new dest
		old2_d = (in_valid1 && dest_arch2 == dest_arch1) ? new_phys1 : map_q[dest_arch2];
		s12_d  = (in_valid1 && src1_arch2 == dest_arch1) ? new_phys1 : map_q[src1_arch2];
		s22_d  = (in_valid1 && src2_arch2 == dest_arch1) ? new_phys1 : map_q[src2_arch2];
	end

	// slot 2 wins the map write on a shared dest
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arf_size; i++) begin
				map_q[i] <= phys_w'(i);	// identity
			end
		end else if (recover) begin
			for (int i = 0; i < arf_size; i++) begin
				map_q[i] <= recovered_map[i*phys_w +: phys_w];
			end
		end else begin
			if (alloc_take1) map_q[dest_arch1] <= new_phys1;
			if (alloc_take2) map_q[dest_arch2] <= new_phys2;
		end
	end

	// output valids
	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid1 <= 1'b0;
			out_valid2 <= 1'b0;
		end else begin
			out_valid1 <= alloc_take1;
			out_valid2 <= alloc_take2;
		end
	end

	// payload regs qualified by out_valid
	always_ff @(posedge clock) begin
		dest_phys1 <= new_phys1;
		dest_phys2 <= new_phys2;
		old_phys1  <= old1_d;
		old_phys2  <= old2_d;
		src1_phys1 <= s11_d;
		src2_phys1 <= s21_d;
		src1_phys2 <= s12_d;
		src2_phys2 <= s22_d;
	end

	always_comb begin
		live = '0;
		for (int i = 0; i < arf_size; i++) begin
			live[map_q[i]] = 1'b1;
		end
	end

	// a reg handed out by the free list must not still be mapped
	assert property (@(posedge clock) disable iff (reset)
		(!alloc_take1 || !live[new_phys1]) && (!alloc_take2 || !live[new_phys2]))
		else $error("rename_map: allocated register is still in the map");

endmodule

// File: verilog/free_list.sv
// free vector over the physical registers with two allocs and two releases per cycle
// offers the two lowest-numbered free regs
// ready needs two free regs even when only one slot renames
// on recover the vector is rebuilt from the committed map and releases that cycle are dropped
`timescale 1ns/1ps

module free_list import rename_pkg::*; #(
	parameter int arf_size = default_arf_size,
	parameter int prf_size = default_prf_size,
	localparam int phys_w = $clog2(prf_size)
) (
	input  logic                       clock,
	input  logic                       reset,
	input  logic                       alloc_take1,
	input  logic                       alloc_take2,
	output logic [phys_w-1:0]          alloc_idx1,
	output logic [phys_w-1:0]          alloc_idx2,
	output logic                       ready,
	input  logic                       free_valid1,
	input  logic [phys_w-1:0]          free_idx1,
	input  logic                       free_valid2,
	input  logic [phys_w-1:0]          free_idx2,
	input  logic                       recover,
	input  logic [arf_size*phys_w-1:0] recovered_map
);

	logic [prf_size-1:0] free_q;	// 1 = free
	logic [prf_size-1:0] free_d;
	logic [prf_size-1:0] named;	// regs held by the recovered map
	logic                found1, found2;
	recovery_state_e     phase;

	// phase follows the one cycle recover pulse
	assign phase = recover ? rec_recover : rec_run;

	//////////////////////////////
	// lowest two free
	//////////////////////////////

	always_comb begin
		found1     = 1'b0;
		found2     = 1'b0;
		alloc_idx1 = '0;
		alloc_idx2 = '0;
		for (int p = 0; p < prf_size; p++) begin
			if (free_q[p]) begin
				if (!found1) begin
					alloc_idx1 = phys_w'(p);
					found1     = 1'b1;
				end else if (!found2) begin
					alloc_idx2 = phys_w'(p);	// second lowest
					found2     = 1'b1;
				end
			end
		end
	end

	assign ready = found2 && (phase == rec_run);

	//////////////////////////////
	// next free vector
	//////////////////////////////

	// every reg named by some arch entry is in use
	always_comb begin
		named = '0;
		for (int i = 0; i < arf_size; i++) begin
			named[recovered_map[i*phys_w +: phys_w]] = 1'b1;
		end
	end

	always_comb begin
		free_d = free_q;
		if (phase == rec_recover) begin
			free_d = ~named;	// rebuild wins over take and release
		end else begin
			if (alloc_take1 && alloc_take2) begin
				free_d[alloc_idx1] = 1'b0;
				free_d[alloc_idx2] = 1'b0;
			end else if (alloc_take1 || alloc_take2) begin
				free_d[alloc_idx1] = 1'b0;	// single take gets the lowest reg
			end
			// a released reg is never on offer so it cannot clash with the takes
			if (free_valid1) free_d[free_idx1] = 1'b1;
			if (free_valid2) free_d[free_idx2] = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int p = 0; p < prf_size; p++) begin
				free_q[p] <= (p >= arf_size);	// identity maps hold 0..arf-1
			end
		end else begin
			free_q <= free_d;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	// every arch reg always holds one mapping so at most prf - arf regs are free
	assert property (@(posedge clock) disable iff (reset)
		$countones(free_q) <= prf_size - arf_size)
		else $error("free_list: more registers free than the maps allow");

	// a release from the retire side must name a reg still held
	assert property (@(posedge clock) disable iff (reset || recover)
		(free_valid1 |-> !free_q[free_idx1]) and
		(free_valid2 |-> !free_q[free_idx2]) and
		((free_valid1 && free_valid2) |-> free_idx1 != free_idx2))
		else $error("free_list: release of a register that is already free");

endmodule

// File: verilog/retire_map.sv
// committed arch to phys map, up to two retires per cycle in program order
// slot 2 is dropped when slot 1 is a mispredict
// a same-arch pair frees the older slot's reg from slot 2
// recovered_map is the committed map itself, read only while recover is high
// no retires are expected during the recover cycle
`timescale 1ns/1ps

module retire_map import retire_pkg::*; #(
	parameter int arf_size,
	parameter int prf_size,
	localparam int arch_w = $clog2(arf_size),
	localparam int phys_w = $clog2(prf_size)
) (
	input  logic                       clock,
	input  logic                       reset,
	input  retire_kind_e               retire_kind1,
	input  logic [arch_w-1:0]          retire_arch1,
	input  logic [phys_w-1:0]          retire_phys1,
	input  retire_kind_e               retire_kind2,
	input  logic [arch_w-1:0]          retire_arch2,
	input  logic [phys_w-1:0]          retire_phys2,
	output logic                       free_valid1,
	output logic [phys_w-1:0]          free_idx1,
	output logic                       free_valid2,
	output logic [phys_w-1:0]          free_idx2,
	output logic                       recover,
	output logic [arf_size*phys_w-1:0] recovered_map
);

	logic [phys_w-1:0] commit_q [arf_size];	// committed map
	logic [phys_w-1:0] commit_d [arf_size];
	logic              slot1, slot2;	// slot commits this cycle
	logic              mispredict;
	logic [phys_w-1:0] free_idx1_d, free_idx2_d;

	//////////////////////////////
	// commit decode
	//////////////////////////////

	assign slot1 = (retire_kind1 != retire_none);
	assign slot2 = (retire_kind2 != retire_none) &&
	               (retire_kind1 != retire_commit_mispredict);	// squashed behind branch

	assign mispredict = (retire_kind1 == retire_commit_mispredict) ||
	                    (slot2 && retire_kind2 == retire_commit_mispredict);

	always_comb begin
		commit_d    = commit_q;
		free_idx1_d = commit_q[retire_arch1];
		// same arch as slot 1, the reg slot 1 just committed is now dead
		free_idx2_d = (slot1 && retire_arch2 == retire_arch1) ? retire_phys1
		                                                       : commit_q[retire_arch2];
		if (slot1) commit_d[retire_arch1] = retire_phys1;
		if (slot2) commit_d[retire_arch2] = retire_phys2;	// younger last
	end

	//////////////////////////////
	// state
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arf_size; i++) begin
				commit_q[i] <= phys_w'(i);	// identity, matches rename_map
			end
			free_valid1 <= 1'b0;
			free_valid2 <= 1'b0;
			recover     <= 1'b0;
		end else begin
			commit_q    <= commit_d;
			free_valid1 <= slot1;
			free_valid2 <= slot2;
			recover     <= mispredict;	// one cycle pulse
		end
	end

	always_ff @(posedge clock) begin
		free_idx1 <= free_idx1_d;
		free_idx2 <= free_idx2_d;
	end

	// flattened snapshot, already holds the mispredicting commit
	always_comb begin
		for (int i = 0; i < arf_size; i++) begin
			recovered_map[i*phys_w +: phys_w] = commit_q[i];
		end
	end

	// a commit never hands back the reg it just installed
	assert property (@(posedge clock) disable iff (reset)
		slot1 |=> (free_valid1 && free_idx1 != $past(retire_phys1)))
		else $error("retire_map: slot 1 released its own register");

	assert property (@(posedge clock) disable iff (reset)
		slot2 |=> (free_valid2 && free_idx2 != $past(retire_phys2)))
		else $error("retire_map: slot 2 released its own register");

endmodule

// File: verilog/rename_top.sv
// two-wide rename unit: speculative map, free list and committed map
// upstream presents a bundle only while rename_ready is high, otherwise it holds
// no back-pressure on the rename outputs
// sizes set here and passed down to every block
`timescale 1ns/1ps

module rename_top import rename_pkg::*, retire_pkg::*; #(
	parameter int arf_size = default_arf_size,
	parameter int prf_size = default_prf_size,
	localparam int arch_w = $clog2(arf_size),
	localparam int phys_w = $clog2(prf_size)
) (
	input  logic              clock,
	input  logic              reset,
	// rename side
	input  logic              in_valid1,
	input  logic              in_valid2,
	input  logic [arch_w-1:0] dest_arch1,
	input  logic [arch_w-1:0] dest_arch2,
	input  logic [arch_w-1:0] src1_arch1,
	input  logic [arch_w-1:0] src2_arch1,
	input  logic [arch_w-1:0] src1_arch2,
	input  logic [arch_w-1:0] src2_arch2,
	output logic              rename_ready,
	output logic              out_valid1,
	output logic              out_valid2,
	output logic [phys_w-1:0] dest_phys1,
	output logic [phys_w-1:0] dest_phys2,
	output logic [phys_w-1:0] old_phys1,
	output logic [phys_w-1:0] old_phys2,
	output logic [phys_w-1:0] src1_phys1,
	output logic [phys_w-1:0] src2_phys1,
	output logic [phys_w-1:0] src1_phys2,
	output logic [phys_w-1:0] src2_phys2,
	// retire side, program order
	input  retire_kind_e      retire_kind1,
	input  logic [arch_w-1:0] retire_arch1,
	input  logic [phys_w-1:0] retire_phys1,
	input  retire_kind_e      retire_kind2,
	input  logic [arch_w-1:0] retire_arch2,
	input  logic [phys_w-1:0] retire_phys2
);

	logic [phys_w-1:0]          alloc_idx1, alloc_idx2;	// free list offer
	logic                       alloc_take1, alloc_take2;
	logic                       free_valid1, free_valid2;	// retire releases
	logic [phys_w-1:0]          free_idx1, free_idx2;
	logic                       recover;
	logic [arf_size*phys_w-1:0] recovered_map;

	rename_map #(.arf_size(arf_size), .prf_size(prf_size)) u_rename_map (
		.clock, .reset,
		.in_valid1, .in_valid2,
		.dest_arch1, .dest_arch2,
		.src1_arch1, .src2_arch1, .src1_arch2, .src2_arch2,
		.alloc_idx1, .alloc_idx2,
		.ready         (rename_ready),
		.alloc_take1, .alloc_take2,
		.recover, .recovered_map,
		.out_valid1, .out_valid2,
		.dest_phys1, .dest_phys2,
		.old_phys1, .old_phys2,
		.src1_phys1, .src2_phys1, .src1_phys2, .src2_phys2
	);

	free_list #(.arf_size(arf_size), .prf_size(prf_size)) u_free_list (
		.clock, .reset,
		.alloc_take1, .alloc_take2,
		.alloc_idx1, .alloc_idx2,
		.ready         (rename_ready),
		.free_valid1, .free_idx1,
		.free_valid2, .free_idx2,
		.recover, .recovered_map
	);

	retire_map #(.arf_size(arf_size), .prf_size(prf_size)) u_retire_map (
		.clock, .reset,
		.retire_kind1, .retire_arch1, .retire_phys1,
		.retire_kind2, .retire_arch2, .retire_phys2,
		.free_valid1, .free_idx1,
		.free_valid2, .free_idx2,
		.recover, .recovered_map
	);

endmodule

// File: verification/rename_checker.sv
// reference model of the rename unit, watches the DUT pins only
// model steps on the rising edge from the inputs, outputs are compared at the falling edge
// allocation is predicted as the lowest free registers
// error_count and check_count are read by the testbench at the end
`timescale 1ns/1ps

module rename_checker import rename_pkg::*, retire_pkg::*; #(
	parameter int arf_size = default_arf_size,
	parameter int prf_size = default_prf_size,
	localparam int arch_w = $clog2(arf_size),
	localparam int phys_w = $clog2(prf_size)
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              in_valid1,
	input  logic              in_valid2,
	input  logic [arch_w-1:0] dest_arch1,
	input  logic [arch_w-1:0] dest_arch2,
	input  logic [arch_w-1:0] src1_arch1,
	input  logic [arch_w-1:0] src2_arch1,
	input  logic [arch_w-1:0] src1_arch2,
	input  logic [arch_w-1:0] src2_arch2,
	input  logic              rename_ready,
	input  logic              out_valid1,
	input  logic              out_valid2,
	input  logic [phys_w-1:0] dest_phys1,
	input  logic [phys_w-1:0] dest_phys2,
	input  logic [phys_w-1:0] old_phys1,
	input  logic [phys_w-1:0] old_phys2,
	input  logic [phys_w-1:0] src1_phys1,
	input  logic [phys_w-1:0] src2_phys1,
	input  logic [phys_w-1:0] src1_phys2,
	input  logic [phys_w-1:0] src2_phys2,
	input  retire_kind_e      retire_kind1,
	input  logic [arch_w-1:0] retire_arch1,
	input  logic [phys_w-1:0] retire_phys1,
	input  retire_kind_e      retire_kind2,
	input  logic [arch_w-1:0] retire_arch2,
	input  logic [phys_w-1:0] retire_phys2,
	output int                error_count,
	output int                check_count
);

	logic [phys_w-1:0]   spec_m [arf_size];	// speculative map
	logic [phys_w-1:0]   commit_m [arf_size];	// committed map
	logic [prf_size-1:0] free_m;	// 1 = free
	logic                rec_m;	// recover cycle
	logic                armed;	// out of reset
	logic                rel_v1, rel_v2;	// releases, land one edge later
	logic [phys_w-1:0]   rel_i1, rel_i2;
	logic [phys_w-1:0]   new1, new2;
	logic                exp_v1, exp_v2;
	logic [phys_w-1:0]   exp_dest [2];
	logic [phys_w-1:0]   exp_old [2];
	logic [phys_w-1:0]   exp_s1 [2];
	logic [phys_w-1:0]   exp_s2 [2];

	initial begin
		error_count = 0;
		check_count = 0;
	end

	// younger slot sees the older slot's new dest
	function automatic logic [phys_w-1:0] slot2_view(input logic [arch_w-1:0] a);
		return (in_valid1 && a == dest_arch1) ? new1 : spec_m[a];
	endfunction

	task automatic check_phys(input string what, input logic [phys_w-1:0] got,
		input logic [phys_w-1:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	//////////////////////////////
	// model update
	//////////////////////////////

	always @(posedge clock) begin : model_step
		logic [phys_w-1:0] a1, a2;
		int                nfree;
		logic              acc, s1, s2;
		a1    = '0;
		a2    = '0;
		nfree = 0;
		for (int p = 0; p < prf_size; p++) begin
			if (free_m[p]) begin
				if (nfree == 0) a1 = phys_w'(p);
				else if (nfree == 1) a2 = phys_w'(p);
				nfree++;
			end
		end
		armed = !reset;
		if (reset) begin
			for (int i = 0; i < arf_size; i++) begin
				spec_m[i]   = phys_w'(i);	// identity
				commit_m[i] = phys_w'(i);
			end
			for (int p = 0; p < prf_size; p++) free_m[p] = (p >= arf_size);
			rec_m  = 1'b0;
			rel_v1 = 1'b0;
			rel_v2 = 1'b0;
			exp_v1 = 1'b0;
			exp_v2 = 1'b0;
		end else begin
			acc  = (nfree >= 2) && !rec_m;	// whole bundle or nothing
			new1 = a1;
			new2 = in_valid1 ? a2 : a1;
			exp_v1 = acc && in_valid1;
			exp_v2 = acc && in_valid2;
			exp_dest[0] = new1;
			exp_old[0]  = spec_m[dest_arch1];
			exp_s1[0]   = spec_m[src1_arch1];
			exp_s2[0]   = spec_m[src2_arch1];
			exp_dest[1] = new2;
			exp_old[1]  = slot2_view(dest_arch2);
			exp_s1[1]   = slot2_view(src1_arch2);
			exp_s2[1]   = slot2_view(src2_arch2);
			if (rec_m) begin
				// rebuild from the committed map, pending releases dropped
				spec_m = commit_m;
				free_m = '1;
				for (int i = 0; i < arf_size; i++) free_m[commit_m[i]] = 1'b0;
			end else begin
				if (exp_v1) spec_m[dest_arch1] = new1;
				if (exp_v2) spec_m[dest_arch2] = new2;	// younger wins
				if (exp_v1) free_m[new1] = 1'b0;
				if (exp_v2) free_m[new2] = 1'b0;
				if (rel_v1) free_m[rel_i1] = 1'b1;
				if (rel_v2) free_m[rel_i2] = 1'b1;
			end
			// retire in program order, slot 2 gone behind a mispredict
			s1 = (retire_kind1 != retire_none);
			s2 = (retire_kind2 != retire_none) && (retire_kind1 != retire_commit_mispredict);
			rel_v1 = s1;
			rel_v2 = s2;
			rel_i1 = commit_m[retire_arch1];
			if (s1) commit_m[retire_arch1] = retire_phys1;
			rel_i2 = commit_m[retire_arch2];	// same arch frees slot 1's reg
			if (s2) commit_m[retire_arch2] = retire_phys2;
			rec_m = (retire_kind1 == retire_commit_mispredict) ||
			        (s2 && retire_kind2 == retire_commit_mispredict);
		end
	end

	//////////////////////////////
	// compare, mid cycle
	//////////////////////////////

	always @(negedge clock) begin
		if (armed) begin
			check_bit("rename_ready", rename_ready, ($countones(free_m) >= 2) && !rec_m);
			check_bit("out_valid1", out_valid1, exp_v1);
			check_bit("out_valid2", out_valid2, exp_v2);
			if (exp_v1 && out_valid1) begin
				check_phys("dest_phys1", dest_phys1, exp_dest[0]);
				check_phys("old_phys1", old_phys1, exp_old[0]);
				check_phys("src1_phys1", src1_phys1, exp_s1[0]);
				check_phys("src2_phys1", src2_phys1, exp_s2[0]);
			end
			if (exp_v2 && out_valid2) begin
				check_phys("dest_phys2", dest_phys2, exp_dest[1]);
				check_phys("old_phys2", old_phys2, exp_old[1]);
				check_phys("src1_phys2", src1_phys2, exp_s1[1]);
				check_phys("src2_phys2", src2_phys2, exp_s2[1]);
			end
		end
	end

endmodule

// File: verification/rename_tb.sv
// testbench for rename_top, random bundles from a fixed seed
// retires replay the renamed stream in order, taken off the DUT outputs
// a bundle offered while rename_ready is low is held on the pins
// value checks live in rename_checker
`timescale 1ns/1ps

module rename_tb import rename_pkg::*, retire_pkg::*; ();

	localparam int arf_size = default_arf_size;
	localparam int prf_size = default_prf_size;
	localparam int arch_w = $clog2(arf_size);
	localparam int phys_w = $clog2(prf_size);

	logic              clock, reset;
	logic              in_valid1, in_valid2, rename_ready;
	logic [arch_w-1:0] dest_arch1, dest_arch2;
	logic [arch_w-1:0] src1_arch1, src2_arch1, src1_arch2, src2_arch2;
	logic              out_valid1, out_valid2;
	logic [phys_w-1:0] dest_phys1, dest_phys2, old_phys1, old_phys2;
	logic [phys_w-1:0] src1_phys1, src2_phys1, src1_phys2, src2_phys2;
	retire_kind_e      retire_kind1, retire_kind2;
	logic [arch_w-1:0] retire_arch1, retire_arch2;
	logic [phys_w-1:0] retire_phys1, retire_phys2;

	int   error_count, check_count;	// from the checker
	int   timeouts = 0;
	int   seed = 96;
	bit   first_bundle = 1'b1;	// both slots right after reset
	bit   last_ready = 1'b1;	// bundle on the pins got taken
	bit   skip_capture = 1'b0;	// outputs squashed by a mispredict
	logic [arch_w-1:0] inflight_arch [$];	// renamed, not retired
	logic [phys_w-1:0] inflight_phys [$];

	rename_top #(.arf_size(arf_size), .prf_size(prf_size)) DUT (.*);
	rename_checker #(.arf_size(arf_size), .prf_size(prf_size)) u_checker (.*);

	always #10 clock = ~clock;	// 20 ns

	// narrow range half the time, so bypass and same-arch retire pairs show up
	function automatic logic [arch_w-1:0] rand_arch();
		int r;
		r = $random(seed);
		if (r[8]) return arch_w'(r[2:0]);
		return r[arch_w-1:0];
	endfunction

	task automatic new_bundle();
		int r;
		r = $random(seed);
		in_valid1    = first_bundle || (r[1:0] != 2'd0);
		in_valid2    = first_bundle || (r[3:2] != 2'd0);
		first_bundle = 1'b0;
		dest_arch1   = rand_arch();
		dest_arch2   = rand_arch();
		src1_arch1   = rand_arch();
		src2_arch1   = rand_arch();
		src1_arch2   = rand_arch();
		src2_arch2   = rand_arch();
	endtask

	// outputs now belong to the bundle still on the pins
	task automatic capture_outputs();
		if (skip_capture) begin
			skip_capture = 1'b0;
		end else begin
			if (out_valid1) begin
				inflight_arch.push_back(dest_arch1);
				inflight_phys.push_back(dest_phys1);
			end
			if (out_valid2) begin
				inflight_arch.push_back(dest_arch2);
				inflight_phys.push_back(dest_phys2);
			end
		end
	endtask

	task automatic drive_retires(input bit enable);
		int r;
		r = $random(seed);
		retire_kind1 = retire_none;
		retire_kind2 = retire_none;
		if (enable && inflight_arch.size() > 0 && r[1:0] != 2'd0) begin
			retire_arch1 = inflight_arch.pop_front();
			retire_phys1 = inflight_phys.pop_front();
			retire_kind1 = (r[7:3] == 5'd0) ? retire_commit_mispredict : retire_commit;
			if (inflight_arch.size() > 0 && r[2]) begin
				retire_arch2 = inflight_arch.pop_front();	// dropped after a mispredict
				retire_phys2 = inflight_phys.pop_front();
				retire_kind2 = retire_commit;
			end
			if (retire_kind1 == retire_commit_mispredict) begin
				inflight_arch.delete();	// everything younger squashed
				inflight_phys.delete();
				skip_capture = 1'b1;
			end
		end
	endtask

	// one cycle of stimulus, all on the falling edge
	task automatic step(input bit retire_en);
		@(negedge clock);
		capture_outputs();
		drive_retires(retire_en);
		if (last_ready) new_bundle();	// else hold the offered bundle
		last_ready = rename_ready;
	endtask

	task automatic wait_for_ready(input bit want, input bit retire_en, input int limit);
		int n;
		n = 0;
		while (rename_ready != want && n < limit) begin
			step(retire_en);
			n++;
		end
		if (rename_ready != want) begin
			timeouts++;
			$display("timeout: rename_ready did not go to %0d within %0d cycles", want, limit);
		end
	endtask

	task automatic run_random(input int cycles);
		for (int i = 0; i < cycles && timeouts == 0; i++) begin
			step(1'b1);
			if (!rename_ready) wait_for_ready(1'b1, 1'b1, 40);
		end
	endtask

	initial begin
		clock        = 1'b0;
		reset        = 1'b1;
		in_valid1    = 1'b0;
		in_valid2    = 1'b0;
		dest_arch1   = '0;
		dest_arch2   = '0;
		src1_arch1   = '0;
		src2_arch1   = '0;
		src1_arch2   = '0;
		src2_arch2   = '0;
		retire_kind1 = retire_none;
		retire_kind2 = retire_none;
		retire_arch1 = '0;
		retire_arch2 = '0;
		retire_phys1 = '0;
		retire_phys2 = '0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		run_random(400);
		// no retires until the free list runs dry, then the held bundle must stay out
		if (timeouts == 0) wait_for_ready(1'b0, 1'b0, prf_size);
		if (timeouts == 0) repeat (4) step(1'b0);
		if (timeouts == 0) wait_for_ready(1'b1, 1'b1, 40);
		run_random(400);
		repeat (2) step(1'b0);

		$display("closing: %0d checks, %0d mismatches, %0d timeouts",
			check_count, error_count, timeouts);
		if (error_count == 0 && timeouts == 0 && check_count > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: rename_unit.f
verilog/rename_pkg.sv
verilog/retire_pkg.sv
verilog/rename_map.sv
verilog/free_list.sv
verilog/retire_map.sv
verilog/rename_top.sv
verification/rename_checker.sv
verification/rename_tb.sv

// File: Makefile
# Verilator build and run for the two-wide rename unit

TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := rename_tb
FILELIST := rename_unit.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q -x -F "$(PASS_MSG)" $(LOG); then \
		echo "result: test passed"; \
	else \
		echo "result: test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
